//--- misc_pkg.sv
// widths fixed by the 32-bit ISA; CSR numbers follow LoongArch32 and only invtlb ops 0, 4 and 5 act
package misc_pkg;

  localparam int TLB_ENTRY_NUM = 8;

  typedef logic [$clog2(TLB_ENTRY_NUM)-1:0] tlb_idx_t;
  typedef logic [31:0] word_t;
  typedef logic [31:0] vaddr_t;
  typedef logic [18:0] vppn_t;
  typedef logic [9:0]  asid_t;
  typedef logic [13:0] csr_addr_t;
  typedef logic [5:0]  rob_idx_t;
  typedef logic [5:0]  preg_t;
  typedef logic [4:0]  invtlb_op_t;

  // csr numbers
  localparam csr_addr_t CSR_TLBIDX  = 14'h010;
  localparam csr_addr_t CSR_TLBEHI  = 14'h011;
  localparam csr_addr_t CSR_TLBELO0 = 14'h012;
  localparam csr_addr_t CSR_TLBELO1 = 14'h013;
  localparam csr_addr_t CSR_ASID    = 14'h018;
  localparam csr_addr_t CSR_SAVE0   = 14'h030;
  localparam csr_addr_t CSR_TID     = 14'h040;

  // invtlb ops that act
  localparam invtlb_op_t INVTLB_ALL     = 5'd0;
  localparam invtlb_op_t INVTLB_ASID    = 5'd4;
  localparam invtlb_op_t INVTLB_ASID_VA = 5'd5;

  typedef enum logic [1:0] {BR_INSTR, PRIV_INSTR, MISC_INSTR} instr_type_e;

  typedef enum logic [3:0] {
    PRIV_NONE, PRIV_CSR_READ, PRIV_CSR_WRITE, PRIV_CSR_XCHG,
    PRIV_TLBSRCH, PRIV_TLBRD, PRIV_TLBWR, PRIV_TLBFILL, PRIV_TLBINV,
    PRIV_ERTN, PRIV_IDLE
  } priv_op_e;

  typedef enum logic [1:0] {MISC_NONE, MISC_RDCNTVL, MISC_RDCNTVH, MISC_RDCNTID} misc_op_e;

  typedef enum logic [2:0] {BEQ, BNE, BLT, BGE, JMP} branch_op_e;

  typedef enum logic {M_IDLE, M_SWEEP} maint_state_e;

  typedef struct packed {
    logic        valid;
    vaddr_t      pc;
    vaddr_t      npc;
    word_t       src0;
    word_t       src1;
    word_t       imm;
    logic        pdest_valid;
    preg_t       pdest;
    rob_idx_t    rob_idx;
    instr_type_e instr_type;
    priv_op_e    priv_op;
    misc_op_e    misc_op;
    branch_op_e  branch_op;
    logic        signed_op;
    logic        indirect;
  } misc_exe_t;

  typedef struct packed {
    logic        valid;
    logic        we;
    word_t       wdata;
    preg_t       pdest;
    rob_idx_t    rob_idx;
    logic        excp;
    instr_type_e instr_type;
    misc_op_e    misc_op;
    logic        csr_we;
    csr_addr_t   csr_waddr;
    word_t       csr_wdata;
    logic        br_taken;
    logic        br_redirect;
    vaddr_t      br_target;
    logic        tlbfill_en;
    tlb_idx_t    tlbfill_idx;
    logic        invtlb_en;
    invtlb_op_t  invtlb_op;
    asid_t       invtlb_asid;
    vaddr_t      vaddr;
    logic        tlbsrch_en;
    logic        tlbsrch_found;
    tlb_idx_t    tlbsrch_idx;
    logic        tlbrd_en;
    word_t       tlbrd_ehi;
    word_t       tlbrd_elo0;
    word_t       tlbrd_elo1;
    asid_t       tlbrd_asid;
    logic        tlbwr_en;
    logic        ertn_en;
    logic        idle_en;
  } misc_wb_t;

  typedef struct packed {
    logic  e;
    vppn_t vppn;
    asid_t asid;
    word_t elo0;
    word_t elo1;
  } tlb_entry_t;

endpackage

//--- branch_unit.sv
// purely combinational; the caller qualifies the outputs with the branch type
`timescale 1ns/10ps

module branch_unit (
  input  logic                   signed_i,
  input  misc_pkg::vaddr_t       pc_i,
  input  misc_pkg::vaddr_t       npc_i,
  input  misc_pkg::word_t        imm_i,
  input  misc_pkg::word_t        src0_i,
  input  misc_pkg::word_t        src1_i,
  input  logic                   indirect_i,
  input  misc_pkg::branch_op_e   branch_op_i,
  output logic                   taken_o,
  output misc_pkg::vaddr_t       target_o,
  output logic                   redirect_o
);
  import misc_pkg::*;

  logic   eq;
  logic   lt;
  vaddr_t next_pc;

  always_comb begin
    eq = src0_i == src1_i;
    lt = signed_i ? ($signed(src0_i) < $signed(src1_i)) : (src0_i < src1_i);
    case (branch_op_i)
      BEQ:     taken_o = eq;
      BNE:     taken_o = !eq;
      BLT:     taken_o = lt;
      BGE:     taken_o = !lt;
      JMP:     taken_o = 1'b1;
      default: taken_o = 1'b0;
    endcase
    // jirl style target when indirect
    target_o   = (indirect_i ? src0_i : pc_i) + imm_i;
    next_pc    = taken_o ? target_o : pc_i + 32'd4;
    redirect_o = next_pc != npc_i;
  end

endmodule

//--- stable_counter.sv
// free-running 64-bit count, wraps silently
`timescale 1ns/10ps

module stable_counter (
  input  logic        clk,
  input  logic        rst_n,
  output logic [63:0] count_o
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_o <= '0;
    end else begin
      count_o <= count_o + 64'd1;
    end
  end

endmodule

//--- csr_file.sv
// only TLB CSRs, SAVE0 and TID exist; other numbers read zero and drop writes, no field masking
`timescale 1ns/10ps

module csr_file (
  input  logic                 clk,
  input  logic                 rst_n,
  input  misc_pkg::csr_addr_t  raddr_i,
  input  misc_pkg::misc_wb_t   commit_i,
  input  logic                 commit_fire_i,
  output misc_pkg::word_t      rdata_o,
  output misc_pkg::word_t      tid_o,
  output misc_pkg::word_t      tlbehi_o,
  output misc_pkg::word_t      tlbelo0_o,
  output misc_pkg::word_t      tlbelo1_o,
  output misc_pkg::word_t      tlbidx_o,
  output misc_pkg::asid_t      asid_o
);
  import misc_pkg::*;

  word_t tlbidx_q;
  word_t tlbehi_q;
  word_t tlbelo0_q;
  word_t tlbelo1_q;
  word_t asid_q;
  word_t save0_q;
  word_t tid_q;

  always_comb begin
    case (raddr_i)
      CSR_TLBIDX:  rdata_o = tlbidx_q;
      CSR_TLBEHI:  rdata_o = tlbehi_q;
      CSR_TLBELO0: rdata_o = tlbelo0_q;
      CSR_TLBELO1: rdata_o = tlbelo1_q;
      CSR_ASID:    rdata_o = asid_q;
      CSR_SAVE0:   rdata_o = save0_q;
      CSR_TID:     rdata_o = tid_q;
      default:     rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tlbidx_q  <= '0;
      tlbehi_q  <= '0;
      tlbelo0_q <= '0;
      tlbelo1_q <= '0;
      asid_q    <= '0;
      save0_q   <= '0;
      tid_q     <= '0;
    end else if (commit_fire_i) begin
      if (commit_i.csr_we) begin
        case (commit_i.csr_waddr)
          CSR_TLBIDX:  tlbidx_q  <= commit_i.csr_wdata;
          CSR_TLBEHI:  tlbehi_q  <= commit_i.csr_wdata;
          CSR_TLBELO0: tlbelo0_q <= commit_i.csr_wdata;
          CSR_TLBELO1: tlbelo1_q <= commit_i.csr_wdata;
          CSR_ASID:    asid_q    <= commit_i.csr_wdata;
          CSR_SAVE0:   save0_q   <= commit_i.csr_wdata;
          CSR_TID:     tid_q     <= commit_i.csr_wdata;
          default: ;
        endcase
      end
      // bit 31 is the not-found flag
      if (commit_i.tlbsrch_en) begin
        tlbidx_q[31]                   <= !commit_i.tlbsrch_found;
        tlbidx_q[$bits(tlb_idx_t)-1:0] <= commit_i.tlbsrch_idx;
      end
      if (commit_i.tlbrd_en) begin
        tlbehi_q  <= commit_i.tlbrd_ehi;
        tlbelo0_q <= commit_i.tlbrd_elo0;
        tlbelo1_q <= commit_i.tlbrd_elo1;
      end
    end
  end

  assign tid_o     = tid_q;
  assign tlbehi_o  = tlbehi_q;
  assign tlbelo0_o = tlbelo0_q;
  assign tlbelo1_o = tlbelo1_q;
  assign tlbidx_o  = tlbidx_q;
  assign asid_o    = asid_q[$bits(asid_t)-1:0];

endmodule

//--- tlb_array.sv
// 8 entries, one page size and no global bit; lowest index wins if a search ever hits twice
`timescale 1ns/10ps

module tlb_array (
  input  logic                   clk,
  input  logic                   rst_n,
  input  misc_pkg::vppn_t        s_vppn_i,
  input  misc_pkg::asid_t        s_asid_i,
  input  misc_pkg::tlb_idx_t     r_idx_i,
  input  logic                   w_en_i,
  input  misc_pkg::tlb_idx_t     w_idx_i,
  input  misc_pkg::tlb_entry_t   w_entry_i,
  input  logic                   inv_en_i,
  input  misc_pkg::tlb_idx_t     inv_idx_i,
  input  misc_pkg::invtlb_op_t   inv_op_i,
  input  misc_pkg::asid_t        inv_asid_i,
  input  misc_pkg::vppn_t        inv_vppn_i,
  output logic                   s_found_o,
  output misc_pkg::tlb_idx_t     s_idx_o,
  output misc_pkg::tlb_entry_t   r_entry_o
);
  import misc_pkg::*;

  tlb_entry_t               mem [TLB_ENTRY_NUM];
  logic [TLB_ENTRY_NUM-1:0] valid_q;
  logic [TLB_ENTRY_NUM-1:0] s_match;
  logic                     inv_hit;

  // search
  always_comb begin
    s_idx_o = '0;
    for (int i = TLB_ENTRY_NUM - 1; i >= 0; i--) begin
      s_match[i] = valid_q[i] && mem[i].vppn == s_vppn_i && mem[i].asid == s_asid_i;
      if (s_match[i]) begin
        s_idx_o = tlb_idx_t'(i);
      end
    end
    s_found_o = |s_match;
  end

  always_comb begin
    r_entry_o   = mem[r_idx_i];
    r_entry_o.e = valid_q[r_idx_i];
  end

  // invalidate rule for the swept entry
  always_comb begin
    case (inv_op_i)
      INVTLB_ALL:     inv_hit = 1'b1;
      INVTLB_ASID:    inv_hit = mem[inv_idx_i].asid == inv_asid_i;
      INVTLB_ASID_VA: inv_hit = mem[inv_idx_i].asid == inv_asid_i &&
                                mem[inv_idx_i].vppn == inv_vppn_i;
      default:        inv_hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (w_en_i) begin
      mem[w_idx_i] <= w_entry_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      if (w_en_i) begin
        valid_q[w_idx_i] <= w_entry_i.e;
      end
      if (inv_en_i && inv_hit) begin
        valid_q[inv_idx_i] <= 1'b0;
      end
    end
  end

  // duplicates would come from a bad tlbwr or tlbfill sequence
  single_hit_a: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(s_match));

endmodule

//--- tlb_maint_fsm.sv
// commit must be held off while busy; an invtlb sweep always runs all 8 entries once started
`timescale 1ns/10ps

module tlb_maint_fsm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  misc_pkg::misc_wb_t     commit_i,
  input  logic                   commit_fire_i,
  input  misc_pkg::word_t        tlbehi_i,
  input  misc_pkg::word_t        tlbelo0_i,
  input  misc_pkg::word_t        tlbelo1_i,
  input  misc_pkg::word_t        tlbidx_i,
  input  misc_pkg::asid_t        asid_i,
  output logic                   busy_o,
  output logic                   w_en_o,
  output misc_pkg::tlb_idx_t     w_idx_o,
  output misc_pkg::tlb_entry_t   w_entry_o,
  output logic                   inv_en_o,
  output misc_pkg::tlb_idx_t     inv_idx_o,
  output misc_pkg::invtlb_op_t   inv_op_o,
  output misc_pkg::asid_t        inv_asid_o,
  output misc_pkg::vppn_t        inv_vppn_o
);
  import misc_pkg::*;

  maint_state_e state;
  tlb_idx_t     sweep_idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= M_IDLE;
      sweep_idx <= '0;
    end else begin
      case (state)
        M_IDLE: begin
          if (commit_fire_i && commit_i.invtlb_en) begin
            state     <= M_SWEEP;
            sweep_idx <= '0;
          end
        end
        M_SWEEP: begin
          sweep_idx <= sweep_idx + 1'b1;
          if (sweep_idx == tlb_idx_t'(TLB_ENTRY_NUM - 1)) begin
            state <= M_IDLE;
          end
        end
        default: state <= M_IDLE;
      endcase
    end
  end

  // match keys held for the whole sweep
  always_ff @(posedge clk) begin
    if (state == M_IDLE && commit_fire_i && commit_i.invtlb_en) begin
      inv_op_o   <= commit_i.invtlb_op;
      inv_asid_o <= commit_i.invtlb_asid;
      inv_vppn_o <= commit_i.vaddr[31:13];
    end
  end

  always_comb begin
    busy_o    = state == M_SWEEP;
    inv_en_o  = busy_o;
    inv_idx_o = sweep_idx;

    // tlbfill goes to the counter-picked slot, tlbwr to TLBIDX
    w_en_o  = state == M_IDLE && commit_fire_i && (commit_i.tlbwr_en || commit_i.tlbfill_en);
    w_idx_o = commit_i.tlbfill_en ? commit_i.tlbfill_idx : tlbidx_i[$bits(tlb_idx_t)-1:0];

    w_entry_o.e    = 1'b1;
    w_entry_o.vppn = tlbehi_i[31:13];
    w_entry_o.asid = asid_i;
    w_entry_o.elo0 = tlbelo0_i;
    w_entry_o.elo1 = tlbelo1_i;
  end

  no_commit_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
    busy_o |-> !commit_fire_i);

endmodule

//--- misc_pipe.sv
// two fixed stages; stage-0 lookups see only committed CSR and TLB state, flush drops both stages
`timescale 1ns/10ps

module misc_pipe (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  input  misc_pkg::misc_exe_t    exe_i,
  output logic                   ready_o,
  output logic                   tlbsrch_valid_o,
  input  logic                   tlbsrch_found_i,
  input  misc_pkg::tlb_idx_t     tlbsrch_idx_i,
  output logic                   tlbrd_valid_o,
  input  misc_pkg::tlb_entry_t   tlbrd_entry_i,
  input  misc_pkg::word_t        csr_rdata_i,
  input  misc_pkg::word_t        tid_i,
  input  logic [63:0]            count_i,
  output misc_pkg::misc_wb_t     wb_o,
  input  logic                   wb_ready_i
);
  import misc_pkg::*;

  logic        s1_ready;
  logic        s2_ready;
  logic        s1_valid;
  misc_exe_t   s1_exe;
  word_t       s1_csr_rdata;
  word_t       s1_tid;
  logic [63:0] s1_count;
  logic        s1_srch_found;
  tlb_idx_t    s1_srch_idx;
  tlb_entry_t  s1_rd_entry;
  logic        s1_is_br;
  logic        s1_is_priv;
  word_t       wdata;
  logic        br_taken;
  logic        br_redirect;
  vaddr_t      br_target;
  misc_wb_t    s1_wb;

  // ============================
  // stage 0
  // ============================
  always_comb begin
    tlbsrch_valid_o = exe_i.valid && exe_i.instr_type == PRIV_INSTR &&
                      exe_i.priv_op == PRIV_TLBSRCH;
    tlbrd_valid_o   = exe_i.valid && exe_i.instr_type == PRIV_INSTR &&
                      exe_i.priv_op == PRIV_TLBRD;
  end

  assign s2_ready = !wb_o.valid || wb_ready_i;
  assign s1_ready = s2_ready || !s1_valid;
  assign ready_o  = s1_ready;

  // ============================
  // stage 1
  // ============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (flush_i) begin
      s1_valid <= 1'b0;
    end else if (s1_ready) begin
      s1_valid <= exe_i.valid;
    end
  end

  // lookup results travel with the instruction
  always_ff @(posedge clk) begin
    if (s1_ready) begin
      s1_exe        <= exe_i;
      s1_csr_rdata  <= csr_rdata_i;
      s1_tid        <= tid_i;
      s1_count      <= count_i;
      s1_srch_found <= tlbsrch_valid_o && tlbsrch_found_i;
      s1_srch_idx   <= tlbsrch_idx_i;
      s1_rd_entry   <= tlbrd_valid_o ? tlbrd_entry_i : '0;
    end
  end

  assign s1_is_br   = s1_valid && s1_exe.instr_type == BR_INSTR;
  assign s1_is_priv = s1_valid && s1_exe.instr_type == PRIV_INSTR;

  branch_unit branch_unit_i (
    .signed_i    (s1_exe.signed_op),
    .pc_i        (s1_exe.pc),
    .npc_i       (s1_exe.npc),
    .imm_i       (s1_exe.imm),
    .src0_i      (s1_exe.src0),
    .src1_i      (s1_exe.src1),
    .indirect_i  (s1_exe.indirect),
    .branch_op_i (s1_exe.branch_op),
    .taken_o     (br_taken),
    .target_o    (br_target),
    .redirect_o  (br_redirect)
  );

  always_comb begin
    case (s1_exe.instr_type)
      BR_INSTR:   wdata = s1_exe.pc + 32'd4;
      PRIV_INSTR: wdata = s1_csr_rdata;
      MISC_INSTR: begin
        case (s1_exe.misc_op)
          MISC_RDCNTVL: wdata = s1_count[31:0];
          MISC_RDCNTVH: wdata = s1_count[63:32];
          MISC_RDCNTID: wdata = s1_tid;
          default:      wdata = '0;
        endcase
      end
      default:    wdata = '0;
    endcase
  end

  always_comb begin
    s1_wb            = '0;
    s1_wb.valid      = s1_valid;
    s1_wb.we         = s1_valid && s1_exe.pdest_valid;
    s1_wb.wdata      = wdata;
    s1_wb.pdest      = s1_exe.pdest;
    s1_wb.rob_idx    = s1_exe.rob_idx;
    s1_wb.instr_type = s1_exe.instr_type;
    s1_wb.misc_op    = s1_exe.misc_op;

    s1_wb.csr_we    = s1_is_priv &&
                      (s1_exe.priv_op == PRIV_CSR_WRITE || s1_exe.priv_op == PRIV_CSR_XCHG);
    s1_wb.csr_waddr = s1_exe.imm[$bits(csr_addr_t)-1:0];
    // xchg merges src0 into the old value under the src1 mask
    s1_wb.csr_wdata = (s1_exe.priv_op == PRIV_CSR_XCHG) ?
                      ((s1_exe.src0 & s1_exe.src1) | (s1_csr_rdata & ~s1_exe.src1)) :
                      s1_exe.src0;

    s1_wb.br_taken    = s1_is_br && br_taken;
    s1_wb.br_redirect = s1_is_br && br_redirect;
    s1_wb.br_target   = br_target;

    s1_wb.tlbfill_en  = s1_is_priv && s1_exe.priv_op == PRIV_TLBFILL;
    s1_wb.tlbfill_idx = s1_count[$bits(tlb_idx_t)-1:0];

    s1_wb.invtlb_en   = s1_is_priv && s1_exe.priv_op == PRIV_TLBINV;
    s1_wb.invtlb_op   = s1_exe.imm[$bits(invtlb_op_t)-1:0];
    s1_wb.invtlb_asid = s1_exe.src0[$bits(asid_t)-1:0];
    s1_wb.vaddr       = s1_exe.src1;

    s1_wb.tlbsrch_en    = s1_is_priv && s1_exe.priv_op == PRIV_TLBSRCH;
    s1_wb.tlbsrch_found = s1_srch_found;
    s1_wb.tlbsrch_idx   = s1_srch_idx;

    s1_wb.tlbrd_en   = s1_is_priv && s1_exe.priv_op == PRIV_TLBRD;
    s1_wb.tlbrd_ehi  = {s1_rd_entry.vppn, 13'd0};
    s1_wb.tlbrd_elo0 = s1_rd_entry.elo0;
    s1_wb.tlbrd_elo1 = s1_rd_entry.elo1;
    s1_wb.tlbrd_asid = s1_rd_entry.asid;

    s1_wb.tlbwr_en = s1_is_priv && s1_exe.priv_op == PRIV_TLBWR;
    s1_wb.ertn_en  = s1_is_priv && s1_exe.priv_op == PRIV_ERTN;
    s1_wb.idle_en  = s1_is_priv && s1_exe.priv_op == PRIV_IDLE;
  end

  // ============================
  // stage 2
  // ============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_o <= '0;
    end else if (flush_i) begin
      wb_o.valid <= 1'b0;
    end else if (s2_ready) begin
      wb_o <= s1_wb;
    end
  end

  // a stalled result must not move until it is taken
  wb_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    wb_o.valid && !wb_ready_i && !flush_i |=> $stable(wb_o));

  one_query_a: assert property (@(posedge clk) disable iff (!rst_n)
    !(tlbsrch_valid_o && tlbrd_valid_o));

endmodule

//--- misc_subsys_top.sv
// commit is stalled during an invtlb sweep; wb_o stays valid and unchanged until the commit side takes it
`timescale 1ns/10ps

module misc_subsys_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush_i,
  input  misc_pkg::misc_exe_t   exe_i,
  input  logic                  wb_ready_i,
  output logic                  ready_o,
  output misc_pkg::misc_wb_t    wb_o
);
  import misc_pkg::*;

  logic        busy;
  logic        commit_fire;
  logic        srch_found;
  tlb_idx_t    srch_idx;
  tlb_entry_t  rd_entry;
  word_t       csr_rdata;
  word_t       tid;
  logic [63:0] count;
  word_t       tlbehi;
  word_t       tlbelo0;
  word_t       tlbelo1;
  word_t       tlbidx;
  asid_t       asid;
  logic        w_en;
  tlb_idx_t    w_idx;
  tlb_entry_t  w_entry;
  logic        inv_en;
  tlb_idx_t    inv_idx;
  invtlb_op_t  inv_op;
  asid_t       inv_asid;
  vppn_t       inv_vppn;

  assign commit_fire = wb_o.valid && wb_ready_i && !busy;

  // ============================
  // execution pipe
  // ============================
  misc_pipe misc_pipe_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush_i         (flush_i),
    .exe_i           (exe_i),
    .ready_o         (ready_o),
    .tlbsrch_valid_o (),
    .tlbsrch_found_i (srch_found),
    .tlbsrch_idx_i   (srch_idx),
    .tlbrd_valid_o   (),
    .tlbrd_entry_i   (rd_entry),
    .csr_rdata_i     (csr_rdata),
    .tid_i           (tid),
    .count_i         (count),
    .wb_o            (wb_o),
    .wb_ready_i      (wb_ready_i && !busy)
  );

  stable_counter stable_counter_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .count_o (count)
  );

  // ============================
  // committed state
  // ============================
  csr_file csr_file_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .raddr_i       (exe_i.imm[$bits(csr_addr_t)-1:0]),
    .commit_i      (wb_o),
    .commit_fire_i (commit_fire),
    .rdata_o       (csr_rdata),
    .tid_o         (tid),
    .tlbehi_o      (tlbehi),
    .tlbelo0_o     (tlbelo0),
    .tlbelo1_o     (tlbelo1),
    .tlbidx_o      (tlbidx),
    .asid_o        (asid)
  );

  tlb_array tlb_array_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .s_vppn_i   (tlbehi[31:13]),
    .s_asid_i   (asid),
    .r_idx_i    (tlbidx[$bits(tlb_idx_t)-1:0]),
    .w_en_i     (w_en),
    .w_idx_i    (w_idx),
    .w_entry_i  (w_entry),
    .inv_en_i   (inv_en),
    .inv_idx_i  (inv_idx),
    .inv_op_i   (inv_op),
    .inv_asid_i (inv_asid),
    .inv_vppn_i (inv_vppn),
    .s_found_o  (srch_found),
    .s_idx_o    (srch_idx),
    .r_entry_o  (rd_entry)
  );

  tlb_maint_fsm tlb_maint_fsm_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .commit_i      (wb_o),
    .commit_fire_i (commit_fire),
    .tlbehi_i      (tlbehi),
    .tlbelo0_i     (tlbelo0),
    .tlbelo1_i     (tlbelo1),
    .tlbidx_i      (tlbidx),
    .asid_i        (asid),
    .busy_o        (busy),
    .w_en_o        (w_en),
    .w_idx_o       (w_idx),
    .w_entry_o     (w_entry),
    .inv_en_o      (inv_en),
    .inv_idx_o     (inv_idx),
    .inv_op_o      (inv_op),
    .inv_asid_o    (inv_asid),
    .inv_vppn_o    (inv_vppn)
  );

endmodule

//--- misc_subsys_tb.sv
// checks commit-side results from a scoreboard; dependent queries wait until the commit queue is idle
`timescale 1ns/10ps

module misc_subsys_tb;
  import misc_pkg::*;

  localparam int TIMEOUT = 200;

  typedef struct packed {
    rob_idx_t rob;
    logic     chk_wdata;
    word_t    wdata;
    logic     chk_inc;
    logic     chk_br;
    logic     taken;
    logic     redirect;
    vaddr_t   target;
    logic     chk_srch;
    logic     found;
    tlb_idx_t sidx;
    logic     chk_rd;
    word_t    ehi;
    word_t    elo0;
    word_t    elo1;
  } exp_t;

  logic      clk;
  logic      rst_n;
  logic      flush_i;
  logic      wb_ready_i;
  logic      ready_o;
  misc_exe_t exe_i;
  misc_wb_t  wb_o;

  exp_t      exp_q[$];
  string     name_q[$];
  rob_idx_t  rob_ctr;
  int        errors;
  int        checks;
  logic      rand_ready;
  logic      hold_ready;
  word_t     last_low;
  logic      commit;

  misc_subsys_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .exe_i      (exe_i),
    .wb_ready_i (wb_ready_i),
    .ready_o    (ready_o),
    .wb_o       (wb_o)
  );

  always #4 clk = !clk;

  always @(negedge clk) begin
    wb_ready_i <= hold_ready ? 1'b0 : (rand_ready ? 1'(($urandom % 3) != 0) : 1'b1);
  end

  assign commit = rst_n && wb_o.valid && wb_ready_i && !dut_i.busy;

  // a stalled write-back holds its value
  wb_stall_a: assert property (@(posedge clk) disable iff (!rst_n)
    wb_o.valid && !(wb_ready_i && !dut_i.busy) && !flush_i |=> $stable(wb_o))
    else begin
      errors++;
      $display("wb_o changed while stalled at %0t", $time);
    end

  task automatic report_diff(input string nm, input string fld, input word_t e, input word_t a);
    errors++;
    $display("mismatch %s %s: expected %h actual %h", nm, fld, e, a);
  endtask

  // ==============================
  // scoreboard
  // ==============================
  always @(posedge clk) begin
    exp_t  e;
    string nm;
    if (commit) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("a write-back committed with nothing expected, rob %0d", wb_o.rob_idx);
      end else begin
        e  = exp_q.pop_front();
        nm = name_q.pop_front();
        checks++;
        assert (wb_o.rob_idx == e.rob) else report_diff(nm, "rob_idx", e.rob, wb_o.rob_idx);
        if (e.chk_wdata)
          assert (wb_o.wdata == e.wdata) else report_diff(nm, "wdata", e.wdata, wb_o.wdata);
        if (e.chk_inc) begin
          assert (wb_o.wdata > last_low)
            else report_diff(nm, "cnt>last", last_low, wb_o.wdata);
          last_low = wb_o.wdata;
        end
        if (e.chk_br) begin
          assert (wb_o.br_taken == e.taken)
            else report_diff(nm, "taken", e.taken, wb_o.br_taken);
          assert (wb_o.br_redirect == e.redirect)
            else report_diff(nm, "redirect", e.redirect, wb_o.br_redirect);
          assert (wb_o.br_target == e.target)
            else report_diff(nm, "target", e.target, wb_o.br_target);
        end
        if (e.chk_srch) begin
          assert (wb_o.tlbsrch_found == e.found)
            else report_diff(nm, "found", e.found, wb_o.tlbsrch_found);
          if (e.found)
            assert (wb_o.tlbsrch_idx == e.sidx)
              else report_diff(nm, "srch_idx", e.sidx, wb_o.tlbsrch_idx);
        end
        if (e.chk_rd) begin
          assert (wb_o.tlbrd_ehi == e.ehi) else report_diff(nm, "ehi", e.ehi, wb_o.tlbrd_ehi);
          assert (wb_o.tlbrd_elo0 == e.elo0)
            else report_diff(nm, "elo0", e.elo0, wb_o.tlbrd_elo0);
          assert (wb_o.tlbrd_elo1 == e.elo1)
            else report_diff(nm, "elo1", e.elo1, wb_o.tlbrd_elo1);
        end
      end
    end
  end

  task automatic give_up(input string what);
    errors++;
    $display("timeout: %s", what);
    $display("checks %0d errors %0d", checks, errors);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  task automatic issue(input misc_exe_t x, input exp_t e, input string nm);
    int n;
    n         = 0;
    x.valid   = 1'b1;
    x.rob_idx = rob_ctr;
    e.rob     = rob_ctr;
    @(negedge clk);
    exe_i = x;
    #1;
    while (!ready_o) begin
      @(negedge clk);
      #1;
      n++;
      if (n > TIMEOUT) give_up("ready_o never rose for issue");
    end
    @(posedge clk);
    exp_q.push_back(e);
    name_q.push_back(nm);
    rob_ctr++;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    @(negedge clk);
    exe_i.valid = 1'b0;
    while (exp_q.size() != 0 || dut_i.busy) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) give_up("pipe never drained");
    end
  endtask

  function automatic misc_exe_t priv(priv_op_e op, csr_addr_t addr, word_t s0, word_t s1);
    misc_exe_t x;
    x             = '0;
    x.instr_type  = PRIV_INSTR;
    x.priv_op     = op;
    x.imm         = word_t'(addr);
    x.src0        = s0;
    x.src1        = s1;
    x.pdest_valid = 1'b1;
    return x;
  endfunction

  function automatic exp_t expect_data(logic chk, word_t d);
    exp_t e;
    e           = '0;
    e.chk_wdata = chk;
    e.wdata     = d;
    return e;
  endfunction

  // one csr op that must commit before the next query
  task automatic csr_op(priv_op_e op, csr_addr_t a, word_t s0, word_t s1, logic chk, word_t d,
                        input string nm);
    issue(priv(op, a, s0, s1), expect_data(chk, d), nm);
    wait_idle();
  endtask

  task automatic search(logic found, tlb_idx_t idx, input string nm);
    exp_t e;
    e          = '0;
    e.chk_srch = 1'b1;
    e.found    = found;
    e.sidx     = idx;
    issue(priv(PRIV_TLBSRCH, '0, '0, '0), e, nm);
    wait_idle();
  endtask

  task automatic branch_case(branch_op_e op, logic sg, logic ind, logic good_guess);
    misc_exe_t x;
    exp_t      e;
    logic      lt;
    vaddr_t    actual;
    x            = '0;
    e            = '0;
    x.instr_type = BR_INSTR;
    x.branch_op  = op;
    x.signed_op  = sg;
    x.indirect   = ind;
    x.pc         = {14'd0, 16'($urandom), 2'b00};
    x.imm        = ($urandom % 2) ? 32'hffff_fff0 : 32'h40;
    x.src0       = ($urandom % 2) ? 32'h8000_0003 : word_t'($urandom % 8);
    x.src1       = ($urandom % 3 == 0) ? x.src0 : word_t'($urandom % 8);
    lt           = sg ? ($signed(x.src0) < $signed(x.src1)) : (x.src0 < x.src1);
    e.chk_br     = 1'b1;
    e.taken      = op == JMP || (op == BEQ && x.src0 == x.src1) ||
                   (op == BNE && x.src0 != x.src1) || (op == BLT && lt) || (op == BGE && !lt);
    e.target     = ind ? x.src0 + x.imm : x.pc + x.imm;
    actual       = e.taken ? e.target : x.pc + 4;
    x.npc        = good_guess ? actual : actual + 8;
    e.redirect   = !good_guess;
    e.chk_wdata  = 1'b1;
    e.wdata      = x.pc + 4;
    issue(x, e, "branch");
  endtask

  initial begin
    exp_t      e;
    misc_exe_t cnt;
    int        n;
    void'($urandom(49));
    clk        = 1'b0;
    rst_n      = 1'b0;
    flush_i    = 1'b0;
    exe_i      = '0;
    wb_ready_i = 1'b0;
    rand_ready = 1'b0;
    hold_ready = 1'b0;
    rob_ctr    = '0;
    errors     = 0;
    checks     = 0;
    last_low   = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // ==============================
    // branches
    // ==============================
    for (int op = 0; op < 5; op++)
      for (int k = 0; k < 8; k++)
        branch_case(branch_op_e'(op), k[0], k[1], k[2]);
    wait_idle();

    // ==============================
    // csr and counter reads
    // ==============================
    csr_op(PRIV_CSR_WRITE, CSR_SAVE0, 32'haaaa_5555, '0, 1'b0, '0, "save0 write");
    csr_op(PRIV_CSR_READ, CSR_SAVE0, '0, '0, 1'b1, 32'haaaa_5555, "save0 read");
    csr_op(PRIV_CSR_XCHG, CSR_SAVE0, 32'h1234_5678, 32'h0000_ffff, 1'b1, 32'haaaa_5555,
           "xchg old");
    csr_op(PRIV_CSR_READ, CSR_SAVE0, '0, '0, 1'b1, 32'haaaa_5678, "xchg merge");
    csr_op(PRIV_CSR_READ, 14'h3ff, '0, '0, 1'b1, '0, "unknown csr");
    csr_op(PRIV_CSR_WRITE, CSR_TID, 32'h0000_beef, '0, 1'b0, '0, "tid write");

    cnt            = '0;
    cnt.instr_type = MISC_INSTR;
    cnt.misc_op    = MISC_RDCNTVL;
    e              = '0;
    e.chk_inc      = 1'b1;
    repeat (4) issue(cnt, e, "rdcntvl");
    cnt.misc_op = MISC_RDCNTVH;
    issue(cnt, expect_data(1'b1, '0), "rdcntvh");
    cnt.misc_op = MISC_RDCNTID;
    issue(cnt, expect_data(1'b1, 32'h0000_beef), "rdcntid");
    wait_idle();

    // ==============================
    // tlb write, search, read
    // ==============================
    csr_op(PRIV_CSR_WRITE, CSR_TLBIDX, 32'd2, '0, 1'b0, '0, "tlbidx");
    csr_op(PRIV_CSR_WRITE, CSR_TLBEHI, 32'h12345 << 13, '0, 1'b0, '0, "tlbehi");
    csr_op(PRIV_CSR_WRITE, CSR_TLBELO0, 32'h0000_1111, '0, 1'b0, '0, "tlbelo0");
    csr_op(PRIV_CSR_WRITE, CSR_TLBELO1, 32'h0000_2222, '0, 1'b0, '0, "tlbelo1");
    csr_op(PRIV_CSR_WRITE, CSR_ASID, 32'd5, '0, 1'b0, '0, "asid");
    csr_op(PRIV_TLBWR, '0, '0, '0, 1'b0, '0, "tlbwr");
    search(1'b1, 3'd2, "search hit");
    e          = '0;
    e.chk_rd   = 1'b1;
    e.ehi      = 32'h12345 << 13;
    e.elo0     = 32'h0000_1111;
    e.elo1     = 32'h0000_2222;
    issue(priv(PRIV_TLBRD, '0, '0, '0), e, "tlbrd");
    wait_idle();
    csr_op(PRIV_CSR_WRITE, CSR_TLBEHI, 32'h00777 << 13, '0, 1'b0, '0, "tlbehi other");
    search(1'b0, '0, "search miss");
    csr_op(PRIV_CSR_WRITE, CSR_TLBEHI, 32'h12345 << 13, '0, 1'b0, '0, "tlbehi back");

    // ==============================
    // invalidate
    // ==============================
    csr_op(PRIV_TLBINV, 14'd4, 32'd7, '0, 1'b0, '0, "invtlb asid");
    search(1'b1, 3'd2, "kept after op 4");
    issue(priv(PRIV_TLBINV, 14'd0, '0, '0), expect_data(1'b0, '0), "invtlb all");
    issue(priv(PRIV_CSR_READ, CSR_SAVE0, '0, '0), expect_data(1'b1, 32'haaaa_5678), "behind 1");
    issue(priv(PRIV_CSR_READ, CSR_SAVE0, '0, '0), expect_data(1'b1, 32'haaaa_5678), "behind 2");
    @(negedge clk);
    exe_i.valid = 1'b0;
    n = 0;
    #1;
    while (!ready_o) begin
      @(negedge clk);
      #1;
      n++;
      if (n > TIMEOUT) give_up("ready_o stuck low after invtlb");
    end
    if (n < TLB_ENTRY_NUM) begin
      errors++;
      $display("ready_o came back after %0d cycles of the sweep", n);
    end
    wait_idle();
    search(1'b0, '0, "gone after op 0");

    // ==============================
    // back-pressure and flush
    // ==============================
    rand_ready = 1'b1;
    for (int i = 0; i < 24; i++)
      issue(priv(PRIV_CSR_READ, CSR_TID, '0, '0), expect_data(1'b1, 32'h0000_beef), "stall");
    wait_idle();
    rand_ready = 1'b0;
    hold_ready = 1'b1;
    issue(priv(PRIV_CSR_READ, CSR_TID, '0, '0), expect_data(1'b0, '0), "flushed");
    issue(priv(PRIV_CSR_READ, CSR_TID, '0, '0), expect_data(1'b0, '0), "flushed");
    @(negedge clk);
    exe_i.valid = 1'b0;
    flush_i     = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    exp_q.delete();
    name_q.delete();
    if (wb_o.valid) begin
      errors++;
      $display("write-back still valid after flush");
    end
    hold_ready = 1'b0;
    repeat (10) @(negedge clk);

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- misc_subsys.f
misc_pkg.sv
branch_unit.sv
stable_counter.sv
csr_file.sv
tlb_array.sv
tlb_maint_fsm.sv
misc_pipe.sv
misc_subsys_top.sv
misc_subsys_tb.sv
